// ==== decodePkg.sv ====
package decodePkg;

	//////////////////////////////
	// Widths and sizes
	//////////////////////////////

	localparam int InstrWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int QueueDepth = 4;
	localparam int QueuePtrWidth = $clog2(QueueDepth);
	localparam int QueueCountWidth = $clog2(QueueDepth + 1);
	localparam logic [RegAddrWidth-1:0] LinkReg = 5'd31;
	localparam logic [1:0] TimeNever = 2'd3;

	// Instruction fields
	localparam int OpHi = 31;
	localparam int OpLo = 26;
	localparam int RsHi = 25;
	localparam int RsLo = 21;
	localparam int RtHi = 20;
	localparam int RtLo = 16;
	localparam int RdHi = 15;
	localparam int RdLo = 11;
	localparam int FuncHi = 5;
	localparam int FuncLo = 0;

	// ALU operand sources
	localparam logic [1:0] AluASrcRs = 2'd0;
	localparam logic [1:0] AluASrcShamt = 2'd1;
	localparam logic [1:0] AluBSrcRt = 2'd0;
	localparam logic [1:0] AluBSrcImm = 2'd1;
	localparam logic [1:0] AluBSrcLink = 2'd2;

	// Data memory access widths
	localparam logic [2:0] LoadWord = 3'd0;
	localparam logic [2:0] LoadByteU = 3'd1;
	localparam logic [2:0] LoadByte = 3'd2;
	localparam logic [2:0] LoadHalfU = 3'd3;
	localparam logic [2:0] LoadHalf = 3'd4;
	localparam logic [2:0] StoreWord = 3'd0;
	localparam logic [2:0] StoreByte = 3'd1;
	localparam logic [2:0] StoreHalf = 3'd2;

	//////////////////////////////
	// Opcodes and functions
	//////////////////////////////

	typedef enum logic [5:0] {
		rType = 6'b000000,
		regImm = 6'b000001,
		opJ = 6'b000010,
		opJal = 6'b000011,
		opBeq = 6'b000100,
		opBne = 6'b000101,
		opBlez = 6'b000110,
		opBgtz = 6'b000111,
		opAddi = 6'b001000,
		opAddiu = 6'b001001,
		opSlti = 6'b001010,
		opSltiu = 6'b001011,
		opAndi = 6'b001100,
		opOri = 6'b001101,
		opXori = 6'b001110,
		opLui = 6'b001111,
		opLb = 6'b100000,
		opLh = 6'b100001,
		opLw = 6'b100011,
		opLbu = 6'b100100,
		opLhu = 6'b100101,
		opSb = 6'b101000,
		opSh = 6'b101001,
		opSw = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll = 6'b000000,
		fnSrl = 6'b000010,
		fnSra = 6'b000011,
		fnSllv = 6'b000100,
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnJr = 6'b001000,
		fnJalr = 6'b001001,
		fnAdd = 6'b100000,
		fnAddu = 6'b100001,
		fnSub = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnNor = 6'b100111,
		fnSlt = 6'b101010,
		fnSltu = 6'b101011
	} funcT;

	// rt field codes under regImm
	typedef enum logic [4:0] {
		rtBltz = 5'b00000,
		rtBgez = 5'b00001,
		rtBgezal = 5'b10001
	} regImmT;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr = 4'd3,
		aluShiftRightLogic = 4'd4,
		aluShiftRightArith = 4'd5,
		aluShiftLeft = 4'd6,
		aluSetLess = 4'd7,
		aluSetLessUnsigned = 4'd8,
		aluNor = 4'd9,
		aluXor = 4'd10,
		aluPassB = 4'd12
	} aluOpT;

	typedef enum logic [2:0] {
		cmpEqual = 3'd0,
		cmpGreaterEqualZero = 3'd1,
		cmpGreaterZero = 3'd2,
		cmpLessEqualZero = 3'd3,
		cmpLessZero = 3'd4,
		cmpNotEqual = 3'd5
	} cmpOpT;

	typedef enum logic [1:0] {extSign = 2'd0, extZero = 2'd1, extUpper = 2'd2} extOpT;

	typedef enum logic [1:0] {
		npcSequential = 2'd0,
		npcBranchOrJump = 2'd1,
		npcRegister = 2'd2
	} npcSelT;

	typedef enum logic {wdAluResult = 1'b0, wdMemData = 1'b1} wdSelT;

	//////////////////////////////
	// Control word and timing
	//////////////////////////////

	typedef struct packed {
		npcSelT npcSel;
		logic npcJump;
		cmpOpT cmpOp;
		extOpT extOp;
		logic [1:0] aluASel;
		logic [1:0] aluBSel;
		aluOpT aluOp;
		logic memRead;
		logic memWrite;
		logic [2:0] loadOp;
		logic [2:0] storeOp;
		wdSelT wdSel;
		logic regWrite;
		logic [RegAddrWidth-1:0] destReg;
		logic [1:0] tNew;
	} ctrlT;

	typedef struct packed {
		logic [1:0] rsUse;
		logic [1:0] rtUse;
	} timingT;

	// One in-flight writer seen by the hazard check
	typedef struct packed {
		logic write;
		logic [RegAddrWidth-1:0] dest;
		logic [1:0] tNew;
	} trackT;

	localparam ctrlT BubbleCtrl = '{
		npcSel: npcSequential,
		npcJump: 1'b0,
		cmpOp: cmpEqual,
		extOp: extSign,
		aluASel: AluASrcRs,
		aluBSel: AluBSrcRt,
		aluOp: aluAdd,
		memRead: 1'b0,
		memWrite: 1'b0,
		loadOp: LoadWord,
		storeOp: StoreWord,
		wdSel: wdAluResult,
		regWrite: 1'b0,
		destReg: '0,
		tNew: 2'd0
	};

	localparam timingT NeverTiming = '{rsUse: TimeNever, rtUse: TimeNever};

endpackage

// ==== instrQueue.sv ====
`timescale 1ns/1ns

module instrQueue (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [decodePkg::InstrWidth-1:0] instr,
	input logic pop,
	output logic headValid,
	output logic [decodePkg::InstrWidth-1:0] headInstr,
	output logic queueFull
);

	logic [decodePkg::InstrWidth-1:0] entries [decodePkg::QueueDepth];
	logic [decodePkg::QueuePtrWidth-1:0] wrPtr;
	logic [decodePkg::QueuePtrWidth-1:0] rdPtr;
	logic [decodePkg::QueueCountWidth-1:0] count;
	logic push;

	// Strobes while full are dropped
	assign push = instrValid && !queueFull;

	assign queueFull = count == decodePkg::QueueCountWidth'(decodePkg::QueueDepth);
	assign headValid = count != '0;
	assign headInstr = entries[rdPtr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= wrPtr + decodePkg::QueuePtrWidth'(1);
			end
			if (pop) begin
				rdPtr <= rdPtr + decodePkg::QueuePtrWidth'(1);
			end
			case ({push, pop})
				2'b10: count <= count + decodePkg::QueueCountWidth'(1);
				2'b01: count <= count - decodePkg::QueueCountWidth'(1);
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wrPtr] <= instr;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Issue only ever takes a real entry
	popNotEmpty: assert property (@(posedge clk) disable iff (reset)
		pop |-> count != '0)
		else $error("instrQueue popped while empty");

	countBounded: assert property (@(posedge clk) disable iff (reset)
		count <= decodePkg::QueueDepth)
		else $error("instrQueue holds more than %0d entries", decodePkg::QueueDepth);

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ns

module instrDecoder (
	input logic [decodePkg::InstrWidth-1:0] instr,
	output decodePkg::ctrlT ctrl,
	output decodePkg::timingT timing
);

	decodePkg::opcodeT op;
	decodePkg::funcT func;
	decodePkg::regImmT branchCode;
	logic [decodePkg::RegAddrWidth-1:0] rs;
	logic [decodePkg::RegAddrWidth-1:0] rt;
	logic [decodePkg::RegAddrWidth-1:0] rd;

	assign op = decodePkg::opcodeT'(instr[decodePkg::OpHi:decodePkg::OpLo]);
	assign func = decodePkg::funcT'(instr[decodePkg::FuncHi:decodePkg::FuncLo]);
	assign branchCode = decodePkg::regImmT'(instr[decodePkg::RtHi:decodePkg::RtLo]);
	assign rs = instr[decodePkg::RsHi:decodePkg::RsLo];
	assign rt = instr[decodePkg::RtHi:decodePkg::RtLo];
	assign rd = instr[decodePkg::RdHi:decodePkg::RdLo];

	always_comb begin
		ctrl = decodePkg::BubbleCtrl;
		timing = decodePkg::NeverTiming;
		case (op)
			decodePkg::rType: begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rd;
				ctrl.tNew = 2'd1;
				timing.rsUse = 2'd1;
				timing.rtUse = 2'd1;
				case (func)
					decodePkg::fnAdd, decodePkg::fnAddu: ctrl.aluOp = decodePkg::aluAdd;
					decodePkg::fnSub, decodePkg::fnSubu: ctrl.aluOp = decodePkg::aluSub;
					decodePkg::fnAnd: ctrl.aluOp = decodePkg::aluAnd;
					decodePkg::fnOr: ctrl.aluOp = decodePkg::aluOr;
					decodePkg::fnNor: ctrl.aluOp = decodePkg::aluNor;
					decodePkg::fnXor: ctrl.aluOp = decodePkg::aluXor;
					decodePkg::fnSlt: ctrl.aluOp = decodePkg::aluSetLess;
					decodePkg::fnSltu: ctrl.aluOp = decodePkg::aluSetLessUnsigned;
					decodePkg::fnSllv: ctrl.aluOp = decodePkg::aluShiftLeft;
					decodePkg::fnSrlv: ctrl.aluOp = decodePkg::aluShiftRightLogic;
					decodePkg::fnSrav: ctrl.aluOp = decodePkg::aluShiftRightArith;
					// Shift by shamt, rs unused
					decodePkg::fnSll: begin
						ctrl.aluASel = decodePkg::AluASrcShamt;
						ctrl.aluOp = decodePkg::aluShiftLeft;
						timing.rsUse = decodePkg::TimeNever;
					end
					decodePkg::fnSra: begin
						ctrl.aluASel = decodePkg::AluASrcShamt;
						ctrl.aluOp = decodePkg::aluShiftRightArith;
						timing.rsUse = decodePkg::TimeNever;
					end
					decodePkg::fnSrl: begin
						ctrl.aluASel = decodePkg::AluASrcShamt;
						ctrl.aluOp = decodePkg::aluShiftRightLogic;
						timing.rsUse = decodePkg::TimeNever;
						// Nonzero rs field is the rotate form
						if (rs != '0) begin
							ctrl = decodePkg::BubbleCtrl;
							timing = decodePkg::NeverTiming;
						end
					end
					decodePkg::fnJr: begin
						ctrl.npcSel = decodePkg::npcRegister;
						ctrl.regWrite = 1'b0;
						ctrl.destReg = '0;
						ctrl.tNew = 2'd0;
						timing.rsUse = 2'd0;
						timing.rtUse = decodePkg::TimeNever;
					end
					decodePkg::fnJalr: begin
						ctrl.npcSel = decodePkg::npcRegister;
						ctrl.aluBSel = decodePkg::AluBSrcLink;
						ctrl.aluOp = decodePkg::aluPassB;
						ctrl.tNew = 2'd0;
						timing.rsUse = 2'd0;
						timing.rtUse = decodePkg::TimeNever;
					end
					default: begin
						ctrl = decodePkg::BubbleCtrl;
						timing = decodePkg::NeverTiming;
					end
				endcase
			end

			// Compare against zero, rt field selects the branch
			decodePkg::regImm: begin
				ctrl.npcSel = decodePkg::npcBranchOrJump;
				timing.rsUse = 2'd0;
				case (branchCode)
					decodePkg::rtBltz: ctrl.cmpOp = decodePkg::cmpLessZero;
					decodePkg::rtBgez: ctrl.cmpOp = decodePkg::cmpGreaterEqualZero;
					decodePkg::rtBgezal: begin
						ctrl.cmpOp = decodePkg::cmpGreaterEqualZero;
						ctrl.aluBSel = decodePkg::AluBSrcLink;
						ctrl.aluOp = decodePkg::aluPassB;
						ctrl.regWrite = 1'b1;
						ctrl.destReg = decodePkg::LinkReg;
						ctrl.tNew = 2'd1;
					end
					default: begin
						ctrl = decodePkg::BubbleCtrl;
						timing = decodePkg::NeverTiming;
					end
				endcase
			end

			decodePkg::opBeq, decodePkg::opBne: begin
				ctrl.npcSel = decodePkg::npcBranchOrJump;
				ctrl.cmpOp = (op == decodePkg::opBeq) ? decodePkg::cmpEqual : decodePkg::cmpNotEqual;
				timing.rsUse = 2'd0;
				timing.rtUse = 2'd0;
			end
			decodePkg::opBlez, decodePkg::opBgtz: begin
				ctrl.npcSel = decodePkg::npcBranchOrJump;
				ctrl.cmpOp = (op == decodePkg::opBlez) ? decodePkg::cmpLessEqualZero
					: decodePkg::cmpGreaterZero;
				timing.rsUse = 2'd0;
			end
			decodePkg::opJ, decodePkg::opJal: begin
				ctrl.npcSel = decodePkg::npcBranchOrJump;
				ctrl.npcJump = 1'b1;
				if (op == decodePkg::opJal) begin
					ctrl.aluBSel = decodePkg::AluBSrcLink;
					ctrl.aluOp = decodePkg::aluPassB;
					ctrl.regWrite = 1'b1;
					ctrl.destReg = decodePkg::LinkReg;
				end
			end

			decodePkg::opAddi, decodePkg::opAddiu, decodePkg::opSlti, decodePkg::opSltiu,
			decodePkg::opAndi, decodePkg::opOri, decodePkg::opXori, decodePkg::opLui: begin
				ctrl.aluBSel = decodePkg::AluBSrcImm;
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.tNew = 2'd1;
				timing.rsUse = 2'd1;
				case (op)
					decodePkg::opSlti: ctrl.aluOp = decodePkg::aluSetLess;
					decodePkg::opSltiu: ctrl.aluOp = decodePkg::aluSetLessUnsigned;
					decodePkg::opAndi: begin
						ctrl.extOp = decodePkg::extZero;
						ctrl.aluOp = decodePkg::aluAnd;
					end
					decodePkg::opOri: begin
						ctrl.extOp = decodePkg::extZero;
						ctrl.aluOp = decodePkg::aluOr;
					end
					decodePkg::opXori: begin
						ctrl.extOp = decodePkg::extZero;
						ctrl.aluOp = decodePkg::aluXor;
					end
					decodePkg::opLui: begin
						ctrl.extOp = decodePkg::extUpper;
						ctrl.aluOp = decodePkg::aluPassB;
						timing.rsUse = decodePkg::TimeNever;
					end
					default: ctrl.aluOp = decodePkg::aluAdd;
				endcase
			end

			// Loads write rt from memory two stages on
			decodePkg::opLw, decodePkg::opLb, decodePkg::opLbu, decodePkg::opLh,
			decodePkg::opLhu: begin
				ctrl.aluBSel = decodePkg::AluBSrcImm;
				ctrl.memRead = 1'b1;
				ctrl.wdSel = decodePkg::wdMemData;
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rt;
				ctrl.tNew = 2'd2;
				timing.rsUse = 2'd1;
				case (op)
					decodePkg::opLb: ctrl.loadOp = decodePkg::LoadByte;
					decodePkg::opLbu: ctrl.loadOp = decodePkg::LoadByteU;
					decodePkg::opLh: ctrl.loadOp = decodePkg::LoadHalf;
					decodePkg::opLhu: ctrl.loadOp = decodePkg::LoadHalfU;
					default: ctrl.loadOp = decodePkg::LoadWord;
				endcase
			end
			decodePkg::opSw, decodePkg::opSb, decodePkg::opSh: begin
				ctrl.aluBSel = decodePkg::AluBSrcImm;
				ctrl.memWrite = 1'b1;
				timing.rsUse = 2'd1;
				timing.rtUse = 2'd2;
				case (op)
					decodePkg::opSb: ctrl.storeOp = decodePkg::StoreByte;
					decodePkg::opSh: ctrl.storeOp = decodePkg::StoreHalf;
					default: ctrl.storeOp = decodePkg::StoreWord;
				endcase
			end

			default: begin
				ctrl = decodePkg::BubbleCtrl;
				timing = decodePkg::NeverTiming;
			end
		endcase
	end

	// A store never reads memory or writes a register from it
	memWriteExclusive: assert final (!(ctrl.memWrite && (ctrl.memRead
		|| (ctrl.regWrite && ctrl.wdSel == decodePkg::wdMemData))))
		else $error("instrDecoder paired a memory write with a memory read");

endmodule

// ==== hazardCheck.sv ====
`timescale 1ns/1ns

module hazardCheck (
	input logic clk,
	input logic reset,
	input logic headValid,
	input logic [decodePkg::InstrWidth-1:0] headInstr,
	input decodePkg::ctrlT headCtrl,
	input decodePkg::timingT headTiming,
	output logic issue,
	output logic stall,
	output logic issueValid,
	output logic [decodePkg::InstrWidth-1:0] issueInstr,
	output decodePkg::ctrlT issueCtrl
);

	decodePkg::trackT stageE;
	decodePkg::trackT stageM;
	logic [decodePkg::RegAddrWidth-1:0] rs;
	logic [decodePkg::RegAddrWidth-1:0] rt;
	logic [1:0] remainE;
	logic [1:0] remainM;
	logic waitE;
	logic waitM;

	// Source still waiting on this writer
	function automatic logic mustWait(
		input logic [decodePkg::RegAddrWidth-1:0] src,
		input logic [1:0] useTime,
		input decodePkg::trackT entry,
		input logic [1:0] remain
	);
		return useTime < decodePkg::TimeNever && src != '0 && entry.write
			&& src == entry.dest && useTime < remain;
	endfunction

	assign rs = headInstr[decodePkg::RsHi:decodePkg::RsLo];
	assign rt = headInstr[decodePkg::RtHi:decodePkg::RtLo];

	// M is one stage further along, floored at zero
	assign remainE = stageE.tNew;
	assign remainM = (stageM.tNew == 2'd0) ? 2'd0 : stageM.tNew - 2'd1;

	assign waitE = mustWait(rs, headTiming.rsUse, stageE, remainE)
		|| mustWait(rt, headTiming.rtUse, stageE, remainE);
	assign waitM = mustWait(rs, headTiming.rsUse, stageM, remainM)
		|| mustWait(rt, headTiming.rtUse, stageM, remainM);

	assign stall = headValid && (waitE || waitM);
	assign issue = headValid && !stall;

	//////////////////////////////
	// Tracking and issue registers
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			stageE <= '0;
			stageM <= '0;
			issueValid <= 1'b0;
		end else begin
			stageM <= stageE;
			if (issue && headCtrl.regWrite) begin
				stageE <= '{write: 1'b1, dest: headCtrl.destReg, tNew: headCtrl.tNew};
			end else begin
				stageE <= '0;
			end
			issueValid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			issueInstr <= headInstr;
			issueCtrl <= headCtrl;
		end
	end

	// Producer leaves both tracked stages within two cycles
	stallBounded: assert property (@(posedge clk) disable iff (reset)
		stall [*2] |=> !stall)
		else $error("hazardCheck stalled for more than two cycles");

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
	input logic clk,
	input logic reset,
	input logic instrValid,
	input logic [decodePkg::InstrWidth-1:0] instr,
	output logic queueFull,
	output logic issueValid,
	output logic [decodePkg::InstrWidth-1:0] issueInstr,
	output decodePkg::ctrlT issueCtrl,
	output logic stall
);

	logic headValid;
	logic [decodePkg::InstrWidth-1:0] headInstr;
	decodePkg::ctrlT headCtrl;
	decodePkg::timingT headTiming;
	logic issue;

	instrQueue queue0 (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.pop(issue),
		.headValid(headValid),
		.headInstr(headInstr),
		.queueFull(queueFull)
	);

	instrDecoder decoder0 (
		.instr(headInstr),
		.ctrl(headCtrl),
		.timing(headTiming)
	);

	hazardCheck hazard0 (
		.clk(clk),
		.reset(reset),
		.headValid(headValid),
		.headInstr(headInstr),
		.headCtrl(headCtrl),
		.headTiming(headTiming),
		.issue(issue),
		.stall(stall),
		.issueValid(issueValid),
		.issueInstr(issueInstr),
		.issueCtrl(issueCtrl)
	);

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock (
	output logic clk,
	output logic reset
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Held for ten rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== decodeStageTb.sv ====
`timescale 1ns/1ns

module decodeStageTb;

	typedef enum logic [1:0] {clsUnknown, clsAlu, clsMem, clsBranch} instrClassT;

	typedef struct packed {
		instrClassT cls;
		decodePkg::ctrlT ctrl;
	} refT;

	logic clk;
	logic reset;
	logic instrValid;
	logic [decodePkg::InstrWidth-1:0] instr;
	logic queueFull;
	logic issueValid;
	logic [decodePkg::InstrWidth-1:0] issueInstr;
	decodePkg::ctrlT issueCtrl;
	logic stall;
	refT expected;

	int errorCount = 0;
	int issuedCount = 0;
	int droppedCount = 0;
	int cycle = 0;
	bit stallSeen = 1'b0;
	bit fullSeen = 1'b0;
	logic [31:0] pending [$];
	int issueCycle [logic [31:0]];

	logic [5:0] regFuncs [16] = '{decodePkg::fnAddu, decodePkg::fnAdd, decodePkg::fnSubu,
		decodePkg::fnSub, decodePkg::fnSlt, decodePkg::fnSltu, decodePkg::fnSll, decodePkg::fnSra,
		decodePkg::fnSrl, decodePkg::fnSllv, decodePkg::fnSrav, decodePkg::fnSrlv, decodePkg::fnAnd,
		decodePkg::fnOr, decodePkg::fnNor, decodePkg::fnXor};
	logic [5:0] immOps [8] = '{decodePkg::opAddi, decodePkg::opAddiu, decodePkg::opSlti,
		decodePkg::opSltiu, decodePkg::opAndi, decodePkg::opOri, decodePkg::opXori, decodePkg::opLui};
	logic [5:0] memOps [8] = '{decodePkg::opLw, decodePkg::opLb, decodePkg::opLbu, decodePkg::opLh,
		decodePkg::opLhu, decodePkg::opSw, decodePkg::opSb, decodePkg::opSh};
	logic [5:0] branchOps [4] = '{decodePkg::opBeq, decodePkg::opBne, decodePkg::opBgtz,
		decodePkg::opBlez};

	tbClock clock0 (
		.clk(clk),
		.reset(reset)
	);

	decodeStage dut0 (
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.queueFull(queueFull),
		.issueValid(issueValid),
		.issueInstr(issueInstr),
		.issueCtrl(issueCtrl),
		.stall(stall)
	);

	//////////////////////////////
	// Reference decode
	//////////////////////////////

	function automatic refT decodeRef(input logic [31:0] word);
		refT r;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		op = word[decodePkg::OpHi:decodePkg::OpLo];
		fn = word[decodePkg::FuncHi:decodePkg::FuncLo];
		rs = word[decodePkg::RsHi:decodePkg::RsLo];
		rt = word[decodePkg::RtHi:decodePkg::RtLo];
		rd = word[decodePkg::RdHi:decodePkg::RdLo];
		r.cls = clsUnknown;
		r.ctrl = '0;
		if (op == decodePkg::rType) begin
			r.cls = clsAlu;
			r.ctrl.regWrite = 1'b1;
			r.ctrl.destReg = rd;
			r.ctrl.tNew = 2'd1;
			case (fn)
				decodePkg::fnAddu, decodePkg::fnAdd: r.ctrl.aluOp = decodePkg::aluAdd;
				decodePkg::fnSubu, decodePkg::fnSub: r.ctrl.aluOp = decodePkg::aluSub;
				decodePkg::fnSlt: r.ctrl.aluOp = decodePkg::aluSetLess;
				decodePkg::fnSltu: r.ctrl.aluOp = decodePkg::aluSetLessUnsigned;
				decodePkg::fnSll, decodePkg::fnSllv: r.ctrl.aluOp = decodePkg::aluShiftLeft;
				decodePkg::fnSrl, decodePkg::fnSrlv: r.ctrl.aluOp = decodePkg::aluShiftRightLogic;
				decodePkg::fnSra, decodePkg::fnSrav: r.ctrl.aluOp = decodePkg::aluShiftRightArith;
				decodePkg::fnAnd: r.ctrl.aluOp = decodePkg::aluAnd;
				decodePkg::fnOr: r.ctrl.aluOp = decodePkg::aluOr;
				decodePkg::fnNor: r.ctrl.aluOp = decodePkg::aluNor;
				decodePkg::fnXor: r.ctrl.aluOp = decodePkg::aluXor;
				decodePkg::fnJr, decodePkg::fnJalr: begin
					r.cls = clsBranch;
					r.ctrl.npcSel = decodePkg::npcRegister;
					r.ctrl.regWrite = (fn == decodePkg::fnJalr);
				end
				default: r.cls = clsUnknown;
			endcase
			// Constant shifts take shamt as operand A
			if (fn == decodePkg::fnSll || fn == decodePkg::fnSrl || fn == decodePkg::fnSra) begin
				r.ctrl.aluASel = decodePkg::AluASrcShamt;
			end
			// Rotate form of srl
			if (fn == decodePkg::fnSrl && rs != 5'd0) begin
				r.cls = clsUnknown;
			end
		end else if (op[5:3] == 3'b001) begin
			r.cls = clsAlu;
			r.ctrl.aluBSel = decodePkg::AluBSrcImm;
			r.ctrl.regWrite = 1'b1;
			r.ctrl.destReg = rt;
			r.ctrl.tNew = 2'd1;
			// Logical immediates zero extend, lui loads the upper half
			if (op[2]) begin
				r.ctrl.extOp = (op[1:0] == 2'b11) ? decodePkg::extUpper : decodePkg::extZero;
			end
			case (op[2:0])
				3'b010: r.ctrl.aluOp = decodePkg::aluSetLess;
				3'b011: r.ctrl.aluOp = decodePkg::aluSetLessUnsigned;
				3'b100: r.ctrl.aluOp = decodePkg::aluAnd;
				3'b101: r.ctrl.aluOp = decodePkg::aluOr;
				3'b110: r.ctrl.aluOp = decodePkg::aluXor;
				3'b111: r.ctrl.aluOp = decodePkg::aluPassB;
				default: r.ctrl.aluOp = decodePkg::aluAdd;
			endcase
		end else if (op[5:4] == 2'b10 && (op[2:0] == 3'b011 || op[2:1] == 2'b00
			|| (op[3] == 1'b0 && op[2:1] == 2'b10))) begin
			r.cls = clsMem;
			r.ctrl.aluBSel = decodePkg::AluBSrcImm;
			if (op[3]) begin
				r.ctrl.memWrite = 1'b1;
				r.ctrl.storeOp = op[1] ? decodePkg::StoreWord
					: (op[0] ? decodePkg::StoreHalf : decodePkg::StoreByte);
			end else begin
				r.ctrl.memRead = 1'b1;
				r.ctrl.wdSel = decodePkg::wdMemData;
				r.ctrl.regWrite = 1'b1;
				r.ctrl.destReg = rt;
				r.ctrl.tNew = 2'd2;
				case (op[2:0])
					3'b000: r.ctrl.loadOp = decodePkg::LoadByte;
					3'b001: r.ctrl.loadOp = decodePkg::LoadHalf;
					3'b100: r.ctrl.loadOp = decodePkg::LoadByteU;
					3'b101: r.ctrl.loadOp = decodePkg::LoadHalfU;
					default: r.ctrl.loadOp = decodePkg::LoadWord;
				endcase
			end
		end else if (op[5:2] == 4'b0001) begin
			r.cls = clsBranch;
			r.ctrl.npcSel = decodePkg::npcBranchOrJump;
			case (op[1:0])
				2'b00: r.ctrl.cmpOp = decodePkg::cmpEqual;
				2'b01: r.ctrl.cmpOp = decodePkg::cmpNotEqual;
				2'b10: r.ctrl.cmpOp = decodePkg::cmpLessEqualZero;
				default: r.ctrl.cmpOp = decodePkg::cmpGreaterZero;
			endcase
		end else if (op[5:1] == 5'b00001) begin
			r.cls = clsBranch;
			r.ctrl.npcSel = decodePkg::npcBranchOrJump;
			r.ctrl.npcJump = 1'b1;
			r.ctrl.regWrite = op[0];
			r.ctrl.destReg = decodePkg::LinkReg;
		end else if (op == decodePkg::regImm && (rt == 5'b00000 || rt[3:0] == 4'b0001)) begin
			r.cls = clsBranch;
			r.ctrl.npcSel = decodePkg::npcBranchOrJump;
			r.ctrl.cmpOp = rt[0] ? decodePkg::cmpGreaterEqualZero : decodePkg::cmpLessZero;
			r.ctrl.regWrite = rt[4];
			r.ctrl.destReg = decodePkg::LinkReg;
		end
		if (r.cls == clsUnknown) begin
			r.ctrl = '0;
		end
		// Link writers pass the return address through the ALU
		if (r.cls == clsBranch && r.ctrl.regWrite) begin
			r.ctrl.aluBSel = decodePkg::AluBSrcLink;
			r.ctrl.aluOp = decodePkg::aluPassB;
		end
		return r;
	endfunction

	assign expected = decodeRef(issueInstr);

	// Only the fields that each check looks at
	function automatic decodePkg::ctrlT aluView(input decodePkg::ctrlT c);
		decodePkg::ctrlT v;
		v = '0;
		v.aluOp = c.aluOp;
		v.aluASel = c.aluASel;
		v.aluBSel = c.aluBSel;
		v.extOp = c.extOp;
		v.destReg = c.destReg;
		v.regWrite = c.regWrite;
		v.tNew = c.tNew;
		return v;
	endfunction

	function automatic decodePkg::ctrlT memView(input decodePkg::ctrlT c);
		decodePkg::ctrlT v;
		v = '0;
		v.memRead = c.memRead;
		v.memWrite = c.memWrite;
		v.loadOp = c.loadOp;
		v.storeOp = c.storeOp;
		v.wdSel = c.wdSel;
		v.regWrite = c.regWrite;
		v.destReg = c.regWrite ? c.destReg : '0;
		return v;
	endfunction

	function automatic decodePkg::ctrlT branchView(input decodePkg::ctrlT c);
		decodePkg::ctrlT v;
		v = '0;
		v.npcSel = c.npcSel;
		v.regWrite = c.regWrite;
		v.destReg = c.regWrite ? c.destReg : '0;
		if (c.regWrite) begin
			v.aluBSel = c.aluBSel;
			v.aluOp = c.aluOp;
		end
		if (c.npcSel == decodePkg::npcBranchOrJump) begin
			v.npcJump = c.npcJump;
			v.cmpOp = c.npcJump ? decodePkg::cmpEqual : c.cmpOp;
		end
		return v;
	endfunction

	function automatic decodePkg::ctrlT unknownView(input decodePkg::ctrlT c);
		decodePkg::ctrlT v;
		v = '0;
		v.regWrite = c.regWrite;
		v.memRead = c.memRead;
		v.memWrite = c.memWrite;
		return v;
	endfunction

	task automatic reportWrong(input string test, input decodePkg::ctrlT exp,
		input decodePkg::ctrlT act);
		errorCount++;
		$display("FAILED %s expected %h actual %h", test, exp, act);
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////

	aluDecode: assert property (@(negedge clk) disable iff (reset)
		issueValid && expected.cls == clsAlu |-> aluView(issueCtrl) == aluView(expected.ctrl))
		else reportWrong("aluDecode", aluView(expected.ctrl), aluView(issueCtrl));

	memDecode: assert property (@(negedge clk) disable iff (reset)
		issueValid && expected.cls == clsMem |-> memView(issueCtrl) == memView(expected.ctrl))
		else reportWrong("memDecode", memView(expected.ctrl), memView(issueCtrl));

	branchDecode: assert property (@(negedge clk) disable iff (reset)
		issueValid && expected.cls == clsBranch
		|-> branchView(issueCtrl) == branchView(expected.ctrl))
		else reportWrong("branchDecode", branchView(expected.ctrl), branchView(issueCtrl));

	unknownDecode: assert property (@(negedge clk) disable iff (reset)
		issueValid && expected.cls == clsUnknown |-> unknownView(issueCtrl) == '0)
		else reportWrong("unknownDecode", '0, unknownView(issueCtrl));

	// Issue order and bookkeeping
	always @(negedge clk) begin
		cycle++;
		if (!reset) begin
			if (stall) begin
				stallSeen = 1'b1;
			end
			if (queueFull) begin
				fullSeen = 1'b1;
			end
			if (issueValid) begin
				issuedCount++;
				issueCycle[issueInstr] = cycle;
				if (pending.size() == 0) begin
					errorCount++;
					$display("Instruction %h issued while nothing was pending", issueInstr);
				end else begin
					pushOrder: assert (issueInstr == pending[0]) else begin
						errorCount++;
						$display("FAILED pushOrder expected %h actual %h", pending[0], issueInstr);
					end
					void'(pending.pop_front());
				end
			end
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	function automatic logic [4:0] randReg();
		return 5'($urandom_range(31));
	endfunction

	function automatic logic [31:0] rWord(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'b000000, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic idleCycles(input int n);
		repeat (n) begin
			@(negedge clk);
			instrValid = 1'b0;
		end
	endtask

	task automatic waitReset();
		int waited;
		waited = 0;
		@(negedge clk);
		while (reset && waited < 50) begin
			@(negedge clk);
			waited++;
		end
		if (reset) begin
			errorCount++;
			$display("Reset was never released");
		end
	endtask

	task automatic pushWhenRoom(input logic [31:0] word);
		int waited;
		waited = 0;
		@(negedge clk);
		while (queueFull && waited < 100) begin
			instrValid = 1'b0;
			@(negedge clk);
			waited++;
		end
		if (queueFull) begin
			errorCount++;
			$display("Timed out waiting for room in the queue");
		end else begin
			instrValid = 1'b1;
			instr = word;
			pending.push_back(word);
		end
	endtask

	// Strobe regardless of queueFull; a strobe seen while full is dropped
	task automatic strobe(input logic [31:0] word);
		@(negedge clk);
		instrValid = 1'b1;
		instr = word;
		if (queueFull) begin
			droppedCount++;
		end else begin
			pending.push_back(word);
		end
	endtask

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (pending.size() != 0 && waited < 100) begin
			@(negedge clk);
			instrValid = 1'b0;
			waited++;
		end
		if (pending.size() != 0) begin
			errorCount++;
			$display("Timed out with %0d instructions still waiting to issue", pending.size());
			pending.delete();
		end
	endtask

	task automatic testDecode();
		logic [5:0] fn;
		for (int i = 0; i < 16; i++) begin
			fn = regFuncs[i];
			pushWhenRoom(rWord(fn, (fn == decodePkg::fnSll || fn == decodePkg::fnSra
				|| fn == decodePkg::fnSrl) ? 5'd0 : randReg(), randReg(), randReg(),
				5'($urandom_range(31))));
		end
		for (int i = 0; i < 8; i++) begin
			pushWhenRoom(iWord(immOps[i], randReg(), randReg(), 16'($urandom)));
			pushWhenRoom(iWord(memOps[i], randReg(), randReg(), 16'($urandom)));
		end
		for (int i = 0; i < 4; i++) begin
			pushWhenRoom(iWord(branchOps[i], randReg(), randReg(), 16'($urandom)));
		end
		pushWhenRoom(iWord(decodePkg::regImm, randReg(), decodePkg::rtBltz, 16'($urandom)));
		pushWhenRoom(iWord(decodePkg::regImm, randReg(), decodePkg::rtBgez, 16'($urandom)));
		pushWhenRoom(iWord(decodePkg::regImm, randReg(), decodePkg::rtBgezal, 16'($urandom)));
		pushWhenRoom({decodePkg::opJ, 26'($urandom)});
		pushWhenRoom({decodePkg::opJal, 26'($urandom)});
		pushWhenRoom(rWord(decodePkg::fnJr, randReg(), 5'd0, 5'd0, 5'd0));
		pushWhenRoom(rWord(decodePkg::fnJalr, randReg(), 5'd0, randReg(), 5'd0));
		// mult, movz, rotate, mul, beql, mfc0
		pushWhenRoom(rWord(6'h18, randReg(), randReg(), 5'd0, 5'd0));
		pushWhenRoom(rWord(6'h0a, randReg(), randReg(), randReg(), 5'd0));
		pushWhenRoom(rWord(decodePkg::fnSrl, 5'd1, randReg(), randReg(), 5'd4));
		pushWhenRoom(iWord(6'h1c, randReg(), randReg(), 16'($urandom)));
		pushWhenRoom(iWord(6'h14, randReg(), randReg(), 16'($urandom)));
		pushWhenRoom({6'h10, 5'd0, randReg(), randReg(), 11'd0});
		waitDrained();
	endtask

	task automatic testLoadUse();
		logic [31:0] load;
		logic [31:0] dependent;
		logic [31:0] loadAgain;
		logic [31:0] independent;
		load = iWord(decodePkg::opLw, 5'd9, 5'd8, 16'h0040);
		dependent = rWord(decodePkg::fnAddu, 5'd8, 5'd11, 5'd10, 5'd0);
		loadAgain = iWord(decodePkg::opLw, 5'd9, 5'd8, 16'h0044);
		independent = rWord(decodePkg::fnAddu, 5'd12, 5'd11, 5'd14, 5'd0);
		// Let both tracked stages empty out
		idleCycles(2);
		stallSeen = 1'b0;
		pushWhenRoom(load);
		pushWhenRoom(dependent);
		waitDrained();
		loadUseStall: assert (stallSeen) else begin
			errorCount++;
			$display("No stall for an addu reading the lw destination");
		end
		loadUseGap: assert (issueCycle[dependent] - issueCycle[load] >= 2) else begin
			errorCount++;
			$display("FAILED loadUseGap expected >= 2 actual %0d",
				issueCycle[dependent] - issueCycle[load]);
		end
		idleCycles(2);
		stallSeen = 1'b0;
		pushWhenRoom(loadAgain);
		pushWhenRoom(independent);
		waitDrained();
		independentNoStall: assert (!stallSeen) else begin
			errorCount++;
			$display("Stall raised for an addu with no dependence on the lw");
		end
		independentGap: assert (issueCycle[independent] - issueCycle[loadAgain] == 1) else begin
			errorCount++;
			$display("FAILED independentGap expected 1 actual %0d",
				issueCycle[independent] - issueCycle[loadAgain]);
		end
	endtask

	// Load-use pairs back to back, each stall grows the queue by one
	task automatic testOverflow();
		fullSeen = 1'b0;
		droppedCount = 0;
		for (int i = 0; i < 12; i++) begin
			strobe(iWord(decodePkg::opLw, 5'd9, 5'd12, 16'(i * 4)));
			strobe(rWord(decodePkg::fnAddu, 5'd12, 5'd12, 5'(i + 1), 5'd0));
		end
		waitDrained();
		queueFills: assert (fullSeen && droppedCount > 0) else begin
			errorCount++;
			$display("Queue never filled up under back-to-back stalls");
		end
	endtask

	initial begin
		void'($urandom(26461));
		instrValid = 1'b0;
		instr = '0;
		waitReset();
		testDecode();
		testLoadUse();
		testOverflow();
		idleCycles(2);
		$display("Issued %0d instructions, dropped %0d strobes, %0d errors",
			issuedCount, droppedCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
decodePkg.sv
instrQueue.sv
instrDecoder.sv
hazardCheck.sv
decodeStage.sv
tbClock.sv
decodeStageTb.sv
